// ==== logic/uart_rx_pkg.sv ====
package uart_rx_pkg;

    // frame geometry
    localparam int DATA_WIDTH = 8;                 // data bits per frame, lsb first on the line
    localparam int BIT_CNT_W  = $clog2(DATA_WIDTH); // width of the data bit index

    // one received byte
    typedef logic [DATA_WIDTH-1:0] rx_byte_t;

    // per-frame error flags
    typedef logic [1:0] rx_err_t;
    localparam int ERR_PARITY = 0;  // parity bit mismatch
    localparam int ERR_FRAME  = 1;  // stop bit sampled low

    // index of the data bit being received
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

    // frame states, data bits share one state plus bit_cnt_t
    typedef enum logic [2:0] {
        IDLE   = 3'd0,  // line idle, hunting for a start edge
        START  = 3'd1,  // waiting for mid start bit
        DATA   = 3'd2,  // data bits, indexed by bit_idx
        PARITY = 3'd3,  // optional parity bit
        STOP   = 3'd4   // stop bit
    } rx_state_t;

endpackage

// ==== logic/rx_bit_if.sv ====
`timescale 1ns/10ps

interface rx_bit_if;
    import uart_rx_pkg::*;

    // sampler side
    logic      start_edge;  // synced high-to-low on the line
    logic      strobe;      // mid-bit sample point
    logic      bit_val;     // synced line level

    // fsm side
    rx_state_t state;       // current frame state
    bit_cnt_t  bit_idx;     // data bit number within DATA
    logic      hunting;     // fsm in IDLE, sampler may re-arm

    modport sampler (output start_edge, strobe, bit_val, input hunting);

    modport fsm (input start_edge, strobe, bit_val, output state, bit_idx, hunting);

    // read-only view for the byte assembler
    modport monitor (input strobe, bit_val, state, bit_idx);

endinterface

// ==== logic/rx_line_sampler.sv ====
`timescale 1ns/10ps

module rx_line_sampler #(
    parameter int CLKS_PER_BIT = 16     // at least 4 clocks per serial bit
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     rx_serial,         // async serial line
    rx_bit_if.sampler bus
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CLKS_PER_BIT / 2 - 1); // start edge to mid start
    localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLKS_PER_BIT - 1);     // mid-bit to mid-bit

    logic             rx_meta;      // first sync flop
    logic             rx_sync;      // second sync flop, the usable line
    logic             rx_prev;      // delayed copy for edge detect
    logic             armed;        // counter running for a frame
    logic [CNT_W-1:0] baud_cnt;     // cycles left to next strobe
    logic             start_edge;
    logic             strobe;

    assign start_edge = rx_prev & ~rx_sync;               // falling edge of synced line
    assign strobe     = armed && (baud_cnt == '0);        // fires once per bit period

    assign bus.start_edge = start_edge;
    assign bus.strobe     = strobe;
    assign bus.bit_val    = rx_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta  <= 1'b1;       // line idles high
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;       // no false edge out of reset
            armed    <= 1'b0;
            baud_cnt <= '0;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;

            if (bus.hunting && start_edge) begin
                armed    <= 1'b1;               // re-arm on every edge seen in idle
                baud_cnt <= HALF_LOAD;          // first strobe lands mid start bit
            end else if (bus.hunting) begin
                armed <= 1'b0;                  // idle without an edge stops the strobes
            end else if (strobe) begin
                baud_cnt <= FULL_LOAD;          // next bit centre
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - CNT_W'(1);
            end
        end
    end

    // the fsm leaves idle on the edge that arms the counter, so
    // a strobe in idle would mean counter and fsm have lost step
    a_no_strobe_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        bus.hunting |-> !strobe
    );

endmodule

// ==== logic/rx_state.sv ====
`timescale 1ns/10ps

module rx_state #(
    parameter int PARITY_EN = 1     // 1 when a parity bit follows the data
) (
    input  logic clk,
    input  logic reset,
    rx_bit_if.fsm bus
);
    import uart_rx_pkg::*;

    localparam bit_cnt_t LAST_IDX = bit_cnt_t'(DATA_WIDTH - 1);   // final data bit

    rx_state_t state_q;
    rx_state_t state_d;
    bit_cnt_t  bit_idx_q;
    bit_cnt_t  bit_idx_d;

    assign bus.state   = state_q;
    assign bus.bit_idx = bit_idx_q;
    assign bus.hunting = (state_q == IDLE);     // lets the sampler re-arm

    always_comb begin
        state_d   = state_q;
        bit_idx_d = bit_idx_q;
        case (state_q)
            IDLE: begin
                if (bus.start_edge) begin
                    state_d = START;            // edge, wait for mid start bit
                end
            end
            START: begin
                if (bus.strobe) begin
                    if (bus.bit_val) begin
                        state_d = IDLE;         // line back high, glitch not a start
                    end else begin
                        state_d   = DATA;
                        bit_idx_d = '0;
                    end
                end
            end
            DATA: begin
                if (bus.strobe) begin
                    if (bit_idx_q == LAST_IDX) begin
                        if (PARITY_EN != 0) begin
                            state_d = PARITY;
                        end else begin
                            state_d = STOP;     // no parity bit on the line
                        end
                    end else begin
                        bit_idx_d = bit_idx_q + bit_cnt_t'(1);
                    end
                end
            end
            PARITY: begin
                if (bus.strobe) begin
                    state_d = STOP;
                end
            end
            STOP: begin
                if (bus.strobe) begin
                    state_d = IDLE;             // stop sampled, assembler closes frame
                end
            end
            default: begin
                state_d = IDLE;                 // unused encodings recover to idle
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= IDLE;
            bit_idx_q <= '0;
        end else begin
            state_q   <= state_d;
            bit_idx_q <= bit_idx_d;
        end
    end

    a_idle_after_reset: assert property (
        @(posedge clk)
        reset |=> (state_q == IDLE)
    );

    a_no_parity_state: assert property (
        @(posedge clk) disable iff (reset)
        (PARITY_EN == 0) |-> (state_q != PARITY)
    );

endmodule

// ==== logic/rx_byte_assembler.sv ====
`timescale 1ns/10ps

module rx_byte_assembler #(
    parameter int PARITY_EN  = 1,   // parity bit present
    parameter int PARITY_ODD = 0    // 1 odd, 0 even
) (
    input  logic                clk,
    input  logic                reset,
    rx_bit_if.monitor           bus,
    output logic                frame_valid,    // one pulse per completed frame
    output uart_rx_pkg::rx_byte_t frame_byte,
    output uart_rx_pkg::rx_err_t  frame_err
);
    import uart_rx_pkg::*;

    localparam logic ODD_SENSE = (PARITY_ODD != 0);   // expected xor of data and parity bit

    rx_byte_t shift_q;      // data bits, lsb arrives first
    logic     par_q;        // running xor of data bits
    logic     par_err_q;    // parity mismatch for current frame

    // control side
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_valid <= 1'b0;
            par_q       <= 1'b0;
            par_err_q   <= 1'b0;
        end else begin
            frame_valid <= 1'b0;                // default, pulse only on stop
            if (bus.strobe) begin
                case (bus.state)
                    DATA: begin
                        if (bus.bit_idx == '0) begin
                            par_q     <= bus.bit_val;   // first bit restarts the parity
                            par_err_q <= 1'b0;          // and drops last frame's flag
                        end else begin
                            par_q <= par_q ^ bus.bit_val;
                        end
                    end
                    PARITY: begin
                        par_err_q <= par_q ^ bus.bit_val ^ ODD_SENSE;
                    end
                    STOP: begin
                        frame_valid <= 1'b1;    // one cycle after the stop strobe
                    end
                    default: ;
                endcase
            end
        end
    end

    // payload side
    always_ff @(posedge clk) begin
        if (bus.strobe && (bus.state == DATA)) begin
            shift_q <= {bus.bit_val, shift_q[DATA_WIDTH-1:1]};  // shift toward lsb
        end
        if (bus.strobe && (bus.state == STOP)) begin
            frame_byte             <= shift_q;
            frame_err[ERR_PARITY]  <= (PARITY_EN != 0) && par_err_q;
            frame_err[ERR_FRAME]   <= ~bus.bit_val;             // stop bit must be high
        end
    end

    // stop lasts one strobe before the fsm is back in idle
    a_valid_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        frame_valid |=> !frame_valid
    );

endmodule

// ==== logic/rx_output_buffer.sv ====
`timescale 1ns/10ps

module rx_output_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  frame_valid,  // new frame from assembler
    input  uart_rx_pkg::rx_byte_t frame_byte,
    input  uart_rx_pkg::rx_err_t  frame_err,
    input  logic                  rx_ready,     // consumer accepts
    output uart_rx_pkg::rx_byte_t rx_data,
    output uart_rx_pkg::rx_err_t  rx_err,
    output logic                  rx_valid,
    output logic                  rx_overrun    // sticky, a frame was lost
);

    logic take;     // held byte leaves this cycle
    logic load;     // incoming frame is stored
    logic drop;     // incoming frame lost, slot still full

    assign take = rx_valid && rx_ready;
    assign load = frame_valid && (!rx_valid || take);   // empty, or emptying now
    assign drop = frame_valid && rx_valid && !rx_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            if (load) begin
                rx_valid <= 1'b1;
            end else if (take) begin
                rx_valid <= 1'b0;
            end

            if (take) begin
                rx_overrun <= 1'b0;     // held byte gone, flag clears
            end else if (drop) begin
                rx_overrun <= 1'b1;     // stays up until the consumer takes the byte
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rx_data <= frame_byte;
            rx_err  <= frame_err;
        end
    end

    // a stalled word must not change or vanish under the consumer
    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data) && $stable(rx_err))
    );

endmodule

// ==== logic/uart_rx_top.sv ====
`timescale 1ns/10ps

module uart_rx_top #(
    parameter int CLKS_PER_BIT = 16,    // clocks per serial bit
    parameter int PARITY_EN    = 1,     // parity bit present
    parameter int PARITY_ODD   = 0      // odd parity when set
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx_serial,
    input  logic                  rx_ready,
    output uart_rx_pkg::rx_byte_t rx_data,
    output uart_rx_pkg::rx_err_t  rx_err,
    output logic                  rx_valid,
    output logic                  rx_overrun
);
    import uart_rx_pkg::*;

    rx_bit_if bit_if ();    // sampler, fsm and assembler share this

    logic     frame_valid;
    rx_byte_t frame_byte;
    rx_err_t  frame_err;

    rx_line_sampler #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) sampler_i (
        .clk       (clk),
        .reset     (reset),
        .rx_serial (rx_serial),
        .bus       (bit_if.sampler)
    );

    rx_state #(
        .PARITY_EN (PARITY_EN)
    ) state_i (
        .clk   (clk),
        .reset (reset),
        .bus   (bit_if.fsm)
    );

    rx_byte_assembler #(
        .PARITY_EN  (PARITY_EN),
        .PARITY_ODD (PARITY_ODD)
    ) assembler_i (
        .clk         (clk),
        .reset       (reset),
        .bus         (bit_if.monitor),
        .frame_valid (frame_valid),
        .frame_byte  (frame_byte),
        .frame_err   (frame_err)
    );

    rx_output_buffer buffer_i (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame_byte  (frame_byte),
        .frame_err   (frame_err),
        .rx_ready    (rx_ready),
        .rx_data     (rx_data),
        .rx_err      (rx_err),
        .rx_valid    (rx_valid),
        .rx_overrun  (rx_overrun)
    );

endmodule

// ==== dv/uart_rx_tb.sv ====
`timescale 1ns/10ps

module uart_rx_tb;
    import uart_rx_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int FRAME_BITS   = 11;                                // start, 8 data, parity, stop
    localparam int VALID_WAIT   = 2 * (FRAME_BITS + 1) * CLKS_PER_BIT; // two frame times in cycles

    logic     clk;
    logic     reset;
    logic     rx_serial;
    logic     rx_ready;
    rx_byte_t rx_data;
    rx_err_t  rx_err;
    logic     rx_valid;
    logic     rx_overrun;

    // test table, columns of dv/uart_rx_testdata.txt:
    // name byte bad_parity bad_stop glitch stall_cycles exp_byte exp_err exp_overrun
    string    t_name[$];
    rx_byte_t t_byte[$];
    int       t_bad_par[$];
    int       t_bad_stop[$];
    int       t_glitch[$];
    int       t_stall[$];
    rx_byte_t t_exp_byte[$];
    rx_err_t  t_exp_err[$];
    int       t_exp_ovr[$];

    int          n_byte_err  = 0;
    int          n_err_err   = 0;
    int          n_bit_err   = 0;
    int          n_proto_err = 0;
    int          limit_ns    = 0;       // watchdog budget
    bit          limit_set   = 1'b0;
    logic [31:0] lcg_state   = 32'd70;  // gap generator seed

    uart_rx_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY_EN    (1),
        .PARITY_ODD   (0)               // even parity
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .rx_serial  (rx_serial),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .rx_err     (rx_err),
        .rx_valid   (rx_valid),
        .rx_overrun (rx_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_byte(input string name, input rx_byte_t exp, input rx_byte_t act);
        if (act !== exp) begin
            n_byte_err++;
            $display("FAIL %s: rx_data expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input rx_err_t exp, input rx_err_t act);
        if (act !== exp) begin
            n_err_err++;
            $display("FAIL %s: rx_err expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            n_bit_err++;
            $display("FAIL %s: flag expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic read_tests();
        int       fd;
        int       code;
        string    name;
        rx_byte_t b;
        int       cp, cs, gl, st;
        rx_byte_t eb;
        rx_err_t  ee;
        int       eo;
        fd = $fopen("dv/uart_rx_testdata.txt", "r");
        if (fd == 0) begin
            n_proto_err++;
            $display("could not open dv/uart_rx_testdata.txt, no tests run");
            return;
        end
        code = 9;
        while (code == 9) begin
            code = $fscanf(fd, "%s %h %d %d %d %d %h %h %d", name, b, cp, cs, gl, st, eb, ee, eo);
            if (code == 9) begin
                t_name.push_back(name);
                t_byte.push_back(b);
                t_bad_par.push_back(cp);
                t_bad_stop.push_back(cs);
                t_glitch.push_back(gl);
                t_stall.push_back(st);
                t_exp_byte.push_back(eb);
                t_exp_err.push_back(ee);
                t_exp_ovr.push_back(eo);
            end
        end
        $fclose(fd);
    endtask

    // one bit cell on the line, entered and left on a falling edge
    task automatic drive_bit(input logic b);
        rx_serial = b;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_frame(input rx_byte_t b, input int bad_par, input int bad_stop);
        logic par;
        par = ^b;                       // even parity over the data bits
        if (bad_par != 0) begin
            par = ~par;
        end
        drive_bit(1'b0);                // start
        for (int i = 0; i < DATA_WIDTH; i++) begin
            drive_bit(b[i]);            // lsb first
        end
        drive_bit(par);
        drive_bit(bad_stop != 0 ? 1'b0 : 1'b1);
        rx_serial = 1'b1;               // back to idle
    endtask

    // low pulse of a quarter bit, then a frame time of idle line
    task automatic send_glitch();
        rx_serial = 1'b0;
        repeat (CLKS_PER_BIT / 4) @(negedge clk);
        rx_serial = 1'b1;
        repeat ((FRAME_BITS + 1) * CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic wait_valid(input string name, output logic seen);
        int cnt;
        cnt = 0;
        while (rx_valid !== 1'b1 && cnt < VALID_WAIT) begin
            @(negedge clk);
            cnt++;
        end
        seen = (rx_valid === 1'b1);
        if (!seen) begin
            n_proto_err++;
            $display("%s: no rx_valid within two frame times after the frame was sent", name);
        end
    endtask

    task automatic take_byte(input string name);
        rx_ready = 1'b1;                // transfer on the next rising edge
        @(negedge clk);
        rx_ready = 1'b0;
        if (rx_valid !== 1'b0) begin
            n_proto_err++;
            $display("%s: rx_valid still high after the byte was taken", name);
        end
        check_flag({name, "/overrun after take"}, 1'b0, rx_overrun);
    endtask

    // watchdog, budget is two runs of 13 bit times per test line
    initial begin
        wait (limit_set);
        #(limit_ns);
        $display("timeout: run still going after %0d ns, stopping", limit_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int   gap;
        logic seen;
        bit   holding;
        rx_serial = 1'b1;               // idle line
        rx_ready  = 1'b0;               // consumer takes explicitly
        reset     = 1'b1;
        holding   = 1'b0;
        read_tests();
        limit_ns  = (t_name.size() + 1) * 13 * CLKS_PER_BIT * 4 * 2;
        limit_set = 1'b1;

        repeat (5) begin
            @(negedge clk);
            check_flag("reset/rx_valid", 1'b0, rx_valid);
            check_flag("reset/rx_overrun", 1'b0, rx_overrun);
        end
        reset = 1'b0;
        repeat (3 * CLKS_PER_BIT) begin
            @(negedge clk);             // idle high line, nothing may come out
            check_flag("idle/rx_valid", 1'b0, rx_valid);
            check_flag("idle/rx_overrun", 1'b0, rx_overrun);
        end

        for (int i = 0; i < t_name.size(); i++) begin
            if (!holding && rx_valid !== 1'b0) begin
                n_proto_err++;
                $display("%s: rx_valid high before the frame was sent", t_name[i]);
            end
            gap = 2 + int'(lcg_next() >> 27);   // 2 to 33 idle cycles
            repeat (gap) @(negedge clk);
            if (t_glitch[i] != 0) begin
                send_glitch();
                if (!holding && rx_valid !== 1'b0) begin
                    n_proto_err++;
                    $display("%s: the short glitch produced an output byte", t_name[i]);
                end
            end
            send_frame(t_byte[i], t_bad_par[i], t_bad_stop[i]);
            wait_valid(t_name[i], seen);
            if (seen) begin
                check_byte(t_name[i], t_exp_byte[i], rx_data);
                check_err(t_name[i], t_exp_err[i], rx_err);
                check_flag({t_name[i], "/overrun"}, (t_exp_ovr[i] != 0), rx_overrun);
            end
            if (t_stall[i] != 0) begin
                holding = 1'b1;         // byte stays, next frame lands on a full buffer
                repeat (t_stall[i]) @(negedge clk);
                check_flag({t_name[i], "/held valid"}, 1'b1, rx_valid);
                check_byte({t_name[i], "/held"}, t_exp_byte[i], rx_data);
            end else if (seen) begin
                take_byte(t_name[i]);
                holding = 1'b0;
            end
        end

        $display("errors: data %0d, error flags %0d, status bits %0d, protocol %0d",
                 n_byte_err, n_err_err, n_bit_err, n_proto_err);
        if (n_byte_err + n_err_err + n_bit_err + n_proto_err == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/uart_rx_testdata.txt ====
clean_00          00 0 0 0 0   00 0 0
clean_ff          ff 0 0 0 0   ff 0 0
clean_55          55 0 0 0 0   55 0 0
clean_aa          aa 0 0 0 0   aa 0 0
clean_01          01 0 0 0 0   01 0 0
clean_80          80 0 0 0 0   80 0 0
clean_3c          3c 0 0 0 0   3c 0 0
clean_c3          c3 0 0 0 0   c3 0 0
clean_7e          7e 0 0 0 0   7e 0 0
clean_96          96 0 0 0 0   96 0 0
par_flip_a5       a5 1 0 0 0   a5 1 0
par_flip_00       00 1 0 0 0   00 1 0
clean_after_par   4d 0 0 0 0   4d 0 0
stop_low_42       42 0 1 0 0   42 2 0
stop_low_ff       ff 0 1 0 0   ff 2 0
par_stop_18       18 1 1 0 0   18 3 0
clean_after_err   e7 0 0 0 0   e7 0 0
glitch_then_5b    5b 0 0 1 0   5b 0 0
glitch_then_00    00 0 0 1 0   00 0 0
hold_first_5a     5a 0 0 0 40  5a 0 0
hold_drop_a5      a5 0 0 0 0   5a 0 1
after_ovr_12      12 0 0 0 0   12 0 0
hold2_first_c0    c0 0 0 0 100 c0 0 0
hold2_drop_bad_0f 0f 1 1 0 0   c0 0 1
tail_ed           ed 0 0 0 0   ed 0 0

// ==== filelist.f ====
logic/uart_rx_pkg.sv
logic/rx_bit_if.sv
logic/rx_line_sampler.sv
logic/rx_state.sv
logic/rx_byte_assembler.sv
logic/rx_output_buffer.sv
logic/uart_rx_top.sv
dv/uart_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the uart receiver testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module uart_rx_tb \
    -f filelist.f \
    -o uart_rx_sim

# the simulation log decides the outcome
./obj_dir/uart_rx_sim | tee "$LOG"

if grep -qx "RESULT: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
